/* design/riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// ----------------------------------------
// rv32i major opcodes, instr[6:0]
// ----------------------------------------
`define RV32I_OPCODE_LUI        7'b0110111
`define RV32I_OPCODE_AUIPC      7'b0010111
`define RV32I_OPCODE_JAL        7'b1101111
`define RV32I_OPCODE_JALR       7'b1100111
`define RV32I_OPCODE_LOAD       7'b0000011
`define RV32I_OPCODE_ARITH_IMM  7'b0010011
`define RV32I_OPCODE_BRANCH     7'b1100011
`define RV32I_OPCODE_STORE      7'b0100011
// shared by rv32i reg-reg ops and rv32m
`define RV32I_OPCODE_ARITH_REG  7'b0110011

// ----------------------------------------
// one-hot instruction class, bit per opcode
// ----------------------------------------
`define ENCODING_NONE       9'b000000000
`define ENCODING_LUI        9'b000000001
`define ENCODING_AUIPC      9'b000000010
`define ENCODING_JAL        9'b000000100
`define ENCODING_JALR       9'b000001000
`define ENCODING_LOAD       9'b000010000
`define ENCODING_ARITH_IMM  9'b000100000
`define ENCODING_BRANCH     9'b001000000
`define ENCODING_STORE      9'b010000000
`define ENCODING_ARITH_REG  9'b100000000

// queue entries, also upstream credits after reset
`define FETCH_Q_DEPTH  4
// downstream buffer depth seen by the issue register
`define ISSUE_CREDITS  2

`endif

/* design/riscv_pkg.sv */
package riscv_pkg;

	// ----------------------------------------
	// raw fetched word
	// ----------------------------------------
	typedef logic [31:0] instr_t;

	// ----------------------------------------
	// decoded bundle fields
	// ----------------------------------------
	// one-hot class, all zero for unknown opcodes
	typedef logic [8:0] encoding_t;

	// instr[31:25], only meaningful for reg-reg ops
	typedef logic [6:0] func7_t;

	// instr[14:12]
	typedef logic [2:0] func3_t;

	// rs1, rs2 and rd indices
	typedef logic [4:0] reg_idx_t;

	// immediate after sign extension
	typedef logic [31:0] imm_t;

endpackage

/* design/decode_if.sv */
interface decode_if import riscv_pkg::*; ();

	// one decoded instruction
	encoding_t encoding;
	func7_t    func7;
	func3_t    func3;
	reg_idx_t  fsrc2;
	reg_idx_t  fsrc1;
	reg_idx_t  fdest;
	imm_t      imm32;
	// unknown opcode
	logic      exception;

	// ----------------------------------------
	// decoder side
	// ----------------------------------------
	modport producer (
		output encoding, func7, func3, fsrc2, fsrc1, fdest, imm32, exception
	);

	// issue register side
	modport consumer (
		input encoding, func7, func3, fsrc2, fsrc1, fdest, imm32, exception
	);

endinterface

/* design/stage1_instruction_decode.sv */
`include "riscv_consts.svh"

module stage1_instruction_decode import riscv_pkg::*; (
	input  instr_t instr_i,
	decode_if.producer dec
);

	// major opcode field
	logic [6:0] opcode;

	assign opcode = instr_i[6:0];

	always_comb begin
		// ----------------------------------------
		// defaults, unused fields stay zero
		// ----------------------------------------
		dec.encoding  = `ENCODING_NONE;
		dec.func7     = '0;
		dec.func3     = '0;
		dec.fsrc2     = '0;
		dec.fsrc1     = '0;
		dec.fdest     = '0;
		dec.imm32     = '0;
		dec.exception = 1'b0;

		case (opcode)
			// u-type, upper 20 bits
			`RV32I_OPCODE_LUI: begin
				dec.encoding = `ENCODING_LUI;
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {instr_i[31:12], 12'h000};
			end
			`RV32I_OPCODE_AUIPC: begin
				dec.encoding = `ENCODING_AUIPC;
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {instr_i[31:12], 12'h000};
			end
			// j-type, scrambled offset with bit 0 forced low
			`RV32I_OPCODE_JAL: begin
				dec.encoding = `ENCODING_JAL;
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
					instr_i[30:21], 1'b0};
			end
			// i-type group
			`RV32I_OPCODE_JALR: begin
				dec.encoding = `ENCODING_JALR;
				dec.fsrc1    = instr_i[19:15];
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			`RV32I_OPCODE_LOAD: begin
				dec.encoding = `ENCODING_LOAD;
				dec.fsrc1    = instr_i[19:15];
				dec.func3    = instr_i[14:12];
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			`RV32I_OPCODE_ARITH_IMM: begin
				dec.encoding = `ENCODING_ARITH_IMM;
				dec.fsrc1    = instr_i[19:15];
				dec.func3    = instr_i[14:12];
				dec.fdest    = instr_i[11:7];
				dec.imm32    = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			// b-type, no rd, offset in two pieces
			`RV32I_OPCODE_BRANCH: begin
				dec.encoding = `ENCODING_BRANCH;
				dec.fsrc2    = instr_i[24:20];
				dec.fsrc1    = instr_i[19:15];
				dec.func3    = instr_i[14:12];
				dec.imm32    = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
					instr_i[11:8], 1'b0};
			end
			// s-type
			`RV32I_OPCODE_STORE: begin
				dec.encoding = `ENCODING_STORE;
				dec.fsrc2    = instr_i[24:20];
				dec.fsrc1    = instr_i[19:15];
				dec.func3    = instr_i[14:12];
				dec.imm32    = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
			end
			// r-type, rv32m told apart later by func7
			`RV32I_OPCODE_ARITH_REG: begin
				dec.encoding = `ENCODING_ARITH_REG;
				{dec.func7, dec.fsrc2, dec.fsrc1, dec.func3, dec.fdest} = instr_i[31:7];
			end
			// system, fence, atomics and junk
			default: begin
				dec.exception = 1'b1;
			end
		endcase
	end

endmodule

/* design/instr_fetch_queue.sv */
`include "riscv_consts.svh"

module instr_fetch_queue import riscv_pkg::*; #(
	parameter int DEPTH = `FETCH_Q_DEPTH
) (
	input  logic   clk_i,
	input  logic   rst_n_i,
	input  logic   push_i,
	input  instr_t instr_i,
	input  logic   pop_i,
	output instr_t head_o,
	output logic   not_empty_o,
	output logic   credit_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	instr_t           mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push_ok;
	logic             pop_ok;

	// ----------------------------------------
	// status and qualified strobes
	// ----------------------------------------
	assign full        = (count == CNT_W'(DEPTH));
	assign not_empty_o = (count != '0);
	assign pop_ok      = pop_i && not_empty_o;
	// full push only lands if a slot frees on the same edge
	assign push_ok     = push_i && (!full || pop_ok);
	assign head_o      = mem[rd_ptr];

	// storage, no reset needed
	always_ff @(posedge clk_i) begin
		if (push_ok)
			mem[wr_ptr] <= instr_i;
	end

	// ----------------------------------------
	// pointers, occupancy, credit pulse
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back upstream per freed slot
			credit_o <= pop_ok;
		end
	end

endmodule

/* design/decode_issue_reg.sv */
`include "riscv_consts.svh"

module decode_issue_reg import riscv_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      not_empty_i,
	output logic      pop_o,
	decode_if.consumer dec,
	input  logic      credit_i,
	output logic      valid_o,
	output encoding_t encoding_o,
	output func7_t    func7_o,
	output func3_t    func3_o,
	output reg_idx_t  fsrc2_o,
	output reg_idx_t  fsrc1_o,
	output reg_idx_t  fdest_o,
	output imm_t      imm32_o,
	output logic      exception_o
);

	localparam int CNT_W = $clog2(`ISSUE_CREDITS + 1);

	// free slots left in the downstream buffer
	logic [CNT_W-1:0] credit_cnt;

	// ----------------------------------------
	// issue decision
	// ----------------------------------------
	// head present and downstream has room
	assign pop_o = not_empty_i && (credit_cnt != '0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_cnt <= CNT_W'(`ISSUE_CREDITS);
			valid_o    <= 1'b0;
		end else begin
			// spend and refund can land together
			credit_cnt <= credit_cnt + CNT_W'(credit_i) - CNT_W'(pop_o);
			// one cycle per issued bundle
			valid_o    <= pop_o;
		end
	end

	// ----------------------------------------
	// bundle capture, payload only
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			encoding_o  <= dec.encoding;
			func7_o     <= dec.func7;
			func3_o     <= dec.func3;
			fsrc2_o     <= dec.fsrc2;
			fsrc1_o     <= dec.fsrc1;
			fdest_o     <= dec.fdest;
			imm32_o     <= dec.imm32;
			exception_o <= dec.exception;
		end
	end

endmodule

/* design/decode_frontend_top.sv */
module decode_frontend_top import riscv_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// upstream, credit based
	input  logic      instr_valid_i,
	input  instr_t    instr_i,
	output logic      instr_credit_o,
	// downstream, credit based
	output logic      dec_valid_o,
	output encoding_t dec_encoding_o,
	output func7_t    dec_func7_o,
	output func3_t    dec_func3_o,
	output reg_idx_t  dec_fsrc2_o,
	output reg_idx_t  dec_fsrc1_o,
	output reg_idx_t  dec_fdest_o,
	output imm_t      dec_imm32_o,
	output logic      dec_exception_o,
	input  logic      dec_credit_i
);

	// ----------------------------------------
	// queue to decode and issue
	// ----------------------------------------
	instr_t head;
	logic   not_empty;
	logic   pop;

	decode_if dec_bus ();

	instr_fetch_queue u_queue (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (instr_valid_i),
		.instr_i     (instr_i),
		.pop_i       (pop),
		.head_o      (head),
		.not_empty_o (not_empty),
		.credit_o    (instr_credit_o)
	);

	// decodes the head word in place
	stage1_instruction_decode u_decode (
		.instr_i (head),
		.dec     (dec_bus)
	);

	decode_issue_reg u_issue (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.not_empty_i (not_empty),
		.pop_o       (pop),
		.dec         (dec_bus),
		.credit_i    (dec_credit_i),
		.valid_o     (dec_valid_o),
		.encoding_o  (dec_encoding_o),
		.func7_o     (dec_func7_o),
		.func3_o     (dec_func3_o),
		.fsrc2_o     (dec_fsrc2_o),
		.fsrc1_o     (dec_fsrc1_o),
		.fdest_o     (dec_fdest_o),
		.imm32_o     (dec_imm32_o),
		.exception_o (dec_exception_o)
	);

endmodule

/* verification/tb_clk_gen.sv */
module tb_clk_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	// free running clock
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// reset held over the first rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* verification/decode_frontend_tb.sv */
`include "riscv_consts.svh"

module decode_frontend_tb import riscv_pkg::*; ();

	localparam int NROWS   = 12;
	localparam int TIMEOUT = 200;

	// word plus expected bundle
	typedef struct packed {
		instr_t    instr;
		encoding_t enc;
		func7_t    f7;
		func3_t    f3;
		reg_idx_t  rs2;
		reg_idx_t  rs1;
		reg_idx_t  rd;
		imm_t      imm;
		logic      exc;
	} row_t;

	row_t      tbl [NROWS];
	logic      clk;
	logic      rst_n;
	logic      instr_valid_i;
	instr_t    instr_i;
	logic      instr_credit_o;
	logic      dec_valid_o;
	encoding_t dec_encoding_o;
	func7_t    dec_func7_o;
	func3_t    dec_func3_o;
	reg_idx_t  dec_fsrc2_o;
	reg_idx_t  dec_fsrc1_o;
	reg_idx_t  dec_fdest_o;
	imm_t      dec_imm32_o;
	logic      dec_exception_o;
	logic      dec_credit_i = 1'b0;

	// upstream and downstream bookkeeping
	int     sent          = 0;
	int     credit_pulses = 0;
	int     rx_cnt        = 0;
	int     returned      = 0;
	bit     sent_any      = 1'b0;
	bit     hold          = 1'b0;
	integer seed          = 98;

	tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	decode_frontend_top dut0 (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.instr_credit_o  (instr_credit_o),
		.dec_valid_o     (dec_valid_o),
		.dec_encoding_o  (dec_encoding_o),
		.dec_func7_o     (dec_func7_o),
		.dec_func3_o     (dec_func3_o),
		.dec_fsrc2_o     (dec_fsrc2_o),
		.dec_fsrc1_o     (dec_fsrc1_o),
		.dec_fdest_o     (dec_fdest_o),
		.dec_imm32_o     (dec_imm32_o),
		.dec_exception_o (dec_exception_o),
		.dec_credit_i    (dec_credit_i)
	);

	// ----------------------------------------
	// error handling and compare tasks
	// ----------------------------------------
	task automatic fail_with(input string reason);
		$display("tests failed");
		$display("%s", reason);
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_enc(input string name, input encoding_t got, input encoding_t exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_f7(input string name, input func7_t got, input func7_t exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_f3(input string name, input func3_t got, input func3_t exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_imm(input string name, input imm_t got, input imm_t exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input bit got, input bit exp);
		if (got !== exp)
			fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// whole bundle against table row
	task automatic check_bundle(input int idx);
		check_enc("dec_encoding_o", dec_encoding_o, tbl[idx].enc);
		check_f7("dec_func7_o", dec_func7_o, tbl[idx].f7);
		check_f3("dec_func3_o", dec_func3_o, tbl[idx].f3);
		check_reg("dec_fsrc2_o", dec_fsrc2_o, tbl[idx].rs2);
		check_reg("dec_fsrc1_o", dec_fsrc1_o, tbl[idx].rs1);
		check_reg("dec_fdest_o", dec_fdest_o, tbl[idx].rd);
		check_imm("dec_imm32_o", dec_imm32_o, tbl[idx].imm);
		check_bit("dec_exception_o", dec_exception_o, tbl[idx].exc);
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	// instr, enc, f7, f3, rs2, rs1, rd, imm, exc
	task automatic load_table();
		tbl[0]  = '{32'h123452B7, `ENCODING_LUI, 7'h00, 3'h0, 5'd0, 5'd0, 5'd5, 32'h12345000, 1'b0};
		tbl[1]  = '{32'hFFFFF517, `ENCODING_AUIPC, 7'h00, 3'h0, 5'd0, 5'd0, 5'd10, 32'hFFFFF000, 1'b0};
		// jal x1, -8
		tbl[2]  = '{32'hFF9FF0EF, `ENCODING_JAL, 7'h00, 3'h0, 5'd0, 5'd0, 5'd1, 32'hFFFFFFF8, 1'b0};
		tbl[3]  = '{32'h00408067, `ENCODING_JALR, 7'h00, 3'h0, 5'd0, 5'd1, 5'd0, 32'h00000004, 1'b0};
		// lw x6, -4(x2)
		tbl[4]  = '{32'hFFC12303, `ENCODING_LOAD, 7'h00, 3'h2, 5'd0, 5'd2, 5'd6, 32'hFFFFFFFC, 1'b0};
		// xori x7, x3, -1
		tbl[5]  = '{32'hFFF1C393, `ENCODING_ARITH_IMM, 7'h00, 3'h4, 5'd0, 5'd3, 5'd7, 32'hFFFFFFFF, 1'b0};
		// ecall is not decoded
		tbl[6]  = '{32'h00000073, `ENCODING_NONE, 7'h00, 3'h0, 5'd0, 5'd0, 5'd0, 32'h00000000, 1'b1};
		// bne x4, x5, -16
		tbl[7]  = '{32'hFE5218E3, `ENCODING_BRANCH, 7'h00, 3'h1, 5'd5, 5'd4, 5'd0, 32'hFFFFFFF0, 1'b0};
		// sw x8, -12(x9)
		tbl[8]  = '{32'hFE84AA23, `ENCODING_STORE, 7'h00, 3'h2, 5'd8, 5'd9, 5'd0, 32'hFFFFFFF4, 1'b0};
		tbl[9]  = '{32'h40D605B3, `ENCODING_ARITH_REG, 7'h20, 3'h0, 5'd13, 5'd12, 5'd11, 32'h0, 1'b0};
		// rv32m div x14, x15, x16
		tbl[10] = '{32'h0307C733, `ENCODING_ARITH_REG, 7'h01, 3'h4, 5'd16, 5'd15, 5'd14, 32'h0, 1'b0};
		tbl[11] = '{32'h0FF0000F, `ENCODING_NONE, 7'h00, 3'h0, 5'd0, 5'd0, 5'd0, 32'h00000000, 1'b1};
	endtask

	// ----------------------------------------
	// upstream driver
	// ----------------------------------------
	task automatic send_row(input int idx);
		int waited;
		waited = 0;
		@(posedge clk);
		// stall while upstream holds no credit
		while (`FETCH_Q_DEPTH - sent + credit_pulses <= 0) begin
			instr_valid_i <= 1'b0;
			waited++;
			if (waited > TIMEOUT)
				fail_with("no upstream credit came back from the queue");
			@(posedge clk);
		end
		instr_valid_i <= 1'b1;
		instr_i       <= tbl[idx].instr;
		sent++;
		sent_any = 1'b1;
	endtask

	task automatic stop_send();
		@(posedge clk);
		instr_valid_i <= 1'b0;
	endtask

	// bundles seen and credits still owed
	task automatic wait_counts(input int rx_target, input int open_target);
		int waited;
		waited = 0;
		while (!(rx_cnt >= rx_target && rx_cnt - returned == open_target)) begin
			waited++;
			if (waited > TIMEOUT)
				fail_with($sformatf("timed out waiting for %0d bundles", rx_target));
			@(negedge clk);
		end
	endtask

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1) begin
			waited++;
			if (waited > TIMEOUT)
				fail_with("reset never released");
			@(posedge clk);
		end
	endtask

	// ----------------------------------------
	// monitor, sampled mid cycle
	// ----------------------------------------
	always @(negedge clk) begin
		if (!sent_any && (dec_valid_o !== 1'b0 || instr_credit_o !== 1'b0))
			fail_with("an output went active before any word was sent");
		if (instr_credit_o === 1'b1)
			credit_pulses++;
		if (dec_valid_o === 1'b1) begin
			if (rx_cnt >= NROWS) begin
				fail_with("more bundles issued than words sent");
			end else begin
				check_bundle(rx_cnt);
				rx_cnt++;
			end
			if (rx_cnt - returned > `ISSUE_CREDITS)
				fail_with("bundles issued beyond the downstream credits");
		end
		// upstream model must never go below zero
		if (sent - credit_pulses > `FETCH_Q_DEPTH)
			fail_with("upstream credit count went negative");
		// nor climb above the queue depth
		if (credit_pulses > sent)
			fail_with("queue returned more credits than words sent");
	end

	// sink, random credit return delay
	always @(posedge clk) begin
		dec_credit_i <= 1'b0;
		if (!hold && returned < rx_cnt && (($random(seed) & 1) != 0)) begin
			dec_credit_i <= 1'b1;
			returned++;
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		instr_valid_i = 1'b0;
		instr_i       = '0;
		load_table();
		wait_reset();
		// idle, monitor watches outputs stay low
		repeat (4) @(negedge clk);
		// lone word, driven at edge n, valid rises at edge n+2
		send_row(0);
		stop_send();
		@(negedge clk);
		check_bit("dec_valid_o", dec_valid_o, 1'b0);
		@(negedge clk);
		check_bit("dec_valid_o", dec_valid_o, 1'b1);
		wait_counts(1, 0);
		// back to back, several in flight
		for (int i = 1; i < 7; i++)
			send_row(i);
		stop_send();
		wait_counts(7, 0);
		// sink holds credits back
		hold = 1'b1;
		for (int i = 7; i < NROWS; i++)
			send_row(i);
		stop_send();
		wait_counts(7 + `ISSUE_CREDITS, `ISSUE_CREDITS);
		repeat (6) @(negedge clk);
		hold = 1'b0;
		wait_counts(NROWS, 0);
		// one upstream credit per word sent
		if (credit_pulses == sent) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_with($sformatf("Mismatch instr_credit_o pulses: got %h expected %h",
				credit_pulses, sent));
		end
	end

endmodule

/* vlog.f */
+incdir+design
design/riscv_pkg.sv
design/decode_if.sv
design/stage1_instruction_decode.sv
design/instr_fetch_queue.sv
design/decode_issue_reg.sv
design/decode_frontend_top.sv
verification/tb_clk_gen.sv
verification/decode_frontend_tb.sv

/* Bender.yml */
package:
  name: decode_frontend

export_include_dirs:
  - design

sources:
  - design/riscv_pkg.sv
  - design/decode_if.sv
  - design/stage1_instruction_decode.sv
  - design/instr_fetch_queue.sv
  - design/decode_issue_reg.sv
  - design/decode_frontend_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/decode_frontend_tb.sv
